// File: src/fsb_axi_pkg.sv
// fsb to axi write adapter: shared widths, register map and bus payload types
`default_nettype none

package fsb_axi_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int FSB_WIDTH   = 80;
  localparam int LANE_WIDTH  = 128;
  localparam int LANES       = 4;
  localparam int DATA_WIDTH  = 512;
  localparam int STRB_WIDTH  = 64;
  // ring offset step, one full data phase
  localparam int PHASE_BYTES = 64;
  localparam int ADDR_WIDTH  = 64;

  // ----------------------------------------------------------
  // wishbone register map, byte offsets
  // ----------------------------------------------------------
  localparam logic [7:0] REG_CTRL     = 8'h00;
  localparam logic [7:0] REG_CMD      = 8'h08;
  localparam logic [7:0] REG_RESET    = 8'h0c;
  localparam logic [7:0] REG_BASE_LO  = 8'h20;
  localparam logic [7:0] REG_BASE_HI  = 8'h24;
  localparam logic [7:0] REG_HEAD     = 8'h28;
  localparam logic [7:0] REG_BUF_SIZE = 8'h30;

  typedef logic [FSB_WIDTH-1:0] fsb_pkt_t;

  // tail record layout, offset in the low word, ones above
  typedef struct packed {
    logic [DATA_WIDTH-33:0] fill;
    logic [31:0]            offset;
  } tail_rec_t;

  // one axi data word, seen as four lanes or as a tail record
  typedef union packed {
    logic [LANES-1:0][LANE_WIDTH-1:0] lane;
    tail_rec_t                        tail;
  } axi_word_u;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [8:0]            id;
  } axi_aw_t;

  typedef struct packed {
    axi_word_u             data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic    awvalid;
    axi_aw_t aw;
    logic    wvalid;
    axi_w_t  w;
  } axi_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axi_wr_rsp_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // config fields and one-cycle command pulses toward the writer
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base;
    logic [31:0]           buf_size;
    logic [31:0]           head;
    logic                  go;
    logic                  stop;
    logic                  reset;
  } ring_cfg_t;

  typedef struct packed {
    logic wr_inp;
    logic stop_pend;
    logic bresp_err;
  } ring_status_t;

endpackage

`default_nettype wire

// File: src/fsb_axi_cfg_regs.sv
// wishbone classic register block: adapter config, go/stop/reset pulses, status readback
`timescale 1ns/100ps
`default_nettype none

module fsb_axi_cfg_regs (
  input  wire                        clk,
  input  wire                        sync_rst_n,
  input  fsb_axi_pkg::wb_req_t       wb_i,
  output fsb_axi_pkg::wb_rsp_t       wb_o,
  input  fsb_axi_pkg::ring_status_t  status_i,
  output fsb_axi_pkg::ring_cfg_t     cfg_o,
  output logic                       fsb_en_o
);

  import fsb_axi_pkg::*;

  // ----------------------------------------------------------
  // bus handshake
  // ----------------------------------------------------------
  logic        wb_req;
  logic        wr_en;
  logic        ack_q;
  logic [31:0] rdat_d;
  logic [31:0] rdat_q;

  // config storage
  logic                  fsb_en_q;
  logic [ADDR_WIDTH-1:0] base_q;
  logic [31:0]           head_q;
  logic [31:0]           size_q;

  // command pulses, live only in the ack cycle
  logic go_pulse;
  logic stop_pulse;
  logic rst_pulse;

  assign wb_req = wb_i.cyc & wb_i.stb;

  // master still holds adr/dat during ack, so writes land here
  assign wr_en = ack_q & wb_req & wb_i.we;

  // single-cycle ack, one clock after the request shows up
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= wb_req & ~ack_q;
  end

  // ----------------------------------------------------------
  // register writes
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      fsb_en_q <= 1'b0;
      base_q   <= '0;
      head_q   <= '0;
      size_q   <= '0;
    end
    else if (wr_en)
    begin
      case (wb_i.adr)
        REG_CTRL:     fsb_en_q       <= wb_i.dat[0];
        REG_BASE_LO:  base_q[31:0]   <= wb_i.dat;
        REG_BASE_HI:  base_q[63:32]  <= wb_i.dat;
        REG_HEAD:     head_q         <= wb_i.dat;
        REG_BUF_SIZE: size_q         <= wb_i.dat;
        default:      ;
      endcase
    end
  end

  // go on bit 0 set, stop on bit 0 clear
  assign go_pulse   = wr_en && (wb_i.adr == REG_CMD) && wb_i.dat[0];
  assign stop_pulse = wr_en && (wb_i.adr == REG_CMD) && !wb_i.dat[0];
  // write reset
  assign rst_pulse  = wr_en && (wb_i.adr == REG_RESET) && wb_i.dat[0];

  // ----------------------------------------------------------
  // readback
  // ----------------------------------------------------------
  always_comb
  begin
    case (wb_i.adr)
      REG_CTRL:     rdat_d = {31'b0, fsb_en_q};
      // status bits share the command offset
      REG_CMD:      rdat_d = {29'b0, status_i.bresp_err, status_i.stop_pend,
                              status_i.wr_inp};
      REG_RESET:    rdat_d = 32'h0;
      REG_BASE_LO:  rdat_d = base_q[31:0];
      REG_BASE_HI:  rdat_d = base_q[63:32];
      REG_HEAD:     rdat_d = head_q;
      REG_BUF_SIZE: rdat_d = size_q;
      // unmapped
      default:      rdat_d = 32'hffff_ffff;
    endcase
  end

  // captured on the edge that raises ack
  always_ff @(posedge clk)
  begin
    if (wb_req && !ack_q)
      rdat_q <= rdat_d;
  end

  assign wb_o = '{ack: ack_q, dat: rdat_q};

  assign cfg_o = '{
    base:     base_q,
    buf_size: size_q,
    head:     head_q,
    go:       go_pulse,
    stop:     stop_pulse,
    reset:    rst_pulse
  };

  assign fsb_en_o = fsb_en_q;

  // master must keep stb up until the ack it caused
  a_ack_needs_stb: assert property (
    @(posedge clk) disable iff (!sync_rst_n)
    wb_o.ack |-> wb_i.stb
  );

endmodule

`default_nettype wire

// File: src/fsb_phase_packer.sv
// fsb phase packer: four 80-bit packets zero-extended into one 512-bit phase, one phase held
`timescale 1ns/100ps
`default_nettype none

module fsb_phase_packer (
  input  wire                     clk,
  input  wire                     sync_rst_n,
  input  wire                     fsb_en_i,
  input  wire                     fsb_valid_i,
  input  fsb_axi_pkg::fsb_pkt_t   fsb_data_i,
  output logic                    fsb_yumi_o,
  output logic                    phase_valid_o,
  output fsb_axi_pkg::axi_word_u  phase_o,
  input  wire                     phase_take_i
);

  import fsb_axi_pkg::*;

  localparam logic [1:0] LAST_LANE = 2'(LANES - 1);

  // lanes 0..2 of the phase under assembly
  logic [LANES-2:0][LANE_WIDTH-1:0] asm_q;
  logic [1:0]                       cnt_q;
  logic [LANE_WIDTH-1:0]            lane_in;
  logic                             room;
  logic                             complete;

  // finished phase waiting for the writer
  axi_word_u hold_q;
  axi_word_u phase_d;
  logic      hold_valid_q;

  // zero-extend packet into its lane
  assign lane_in = {{(LANE_WIDTH-FSB_WIDTH){1'b0}}, fsb_data_i};

  // ----------------------------------------------------------
  // flow control
  // ----------------------------------------------------------
  // first three lanes always fit
  // last lane needs the holding slot free or draining now
  assign room = (cnt_q != LAST_LANE) || !hold_valid_q || phase_take_i;

  assign fsb_yumi_o = fsb_valid_i && fsb_en_i && room;
  assign complete   = fsb_yumi_o && (cnt_q == LAST_LANE);

  // incoming packet closes the word in lane 3
  always_comb
  begin
    phase_d.lane = {lane_in, asm_q};
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      cnt_q <= '0;
    else if (fsb_yumi_o)
      cnt_q <= cnt_q + 2'd1;
  end

  always_ff @(posedge clk)
  begin
    if (fsb_yumi_o && (cnt_q != LAST_LANE))
      asm_q[cnt_q] <= lane_in;
  end

  // ----------------------------------------------------------
  // holding slot
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      hold_valid_q <= 1'b0;
    else if (complete)
      hold_valid_q <= 1'b1;
    else if (phase_take_i)
      hold_valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (complete)
      hold_q <= phase_d;
  end

  assign phase_valid_o = hold_valid_q;
  assign phase_o       = hold_q;

  // held phase stays put until the writer takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!sync_rst_n)
    (phase_valid_o && !phase_take_i) |=> (phase_valid_o && $stable(phase_o))
  );

endmodule

`default_nettype wire

// File: src/hm_ring_writer.sv
// host memory ring writer: axi4 single-beat data writes, each followed by a tail offset record
`timescale 1ns/100ps
`default_nettype none

module hm_ring_writer (
  input  wire                        clk,
  input  wire                        sync_rst_n,
  input  fsb_axi_pkg::ring_cfg_t     cfg_i,
  output fsb_axi_pkg::ring_status_t  status_o,
  input  wire                        phase_valid_i,
  input  fsb_axi_pkg::axi_word_u     phase_i,
  output logic                       phase_take_o,
  output fsb_axi_pkg::axi_wr_req_t   axi_o,
  input  fsb_axi_pkg::axi_wr_rsp_t   axi_i
);

  import fsb_axi_pkg::*;

  // ----------------------------------------------------------
  // state encoding
  // ----------------------------------------------------------
  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_WAIT     = 3'd1;
  localparam logic [2:0] ST_DATA_REQ = 3'd2;
  localparam logic [2:0] ST_DATA_RSP = 3'd3;
  localparam logic [2:0] ST_TAIL_REQ = 3'd4;
  localparam logic [2:0] ST_TAIL_RSP = 3'd5;
  localparam logic [2:0] ST_CHECK    = 3'd6;

  // tail record covers the low 8 bytes
  localparam logic [STRB_WIDTH-1:0] TAIL_STRB = 64'h0000_0000_0000_00ff;

  logic [2:0] state_q;
  logic [2:0] state_d;

  // ring offset, relative to base
  logic [31:0] off_q;
  logic [31:0] off_inc;
  logic [31:0] nxt_off;
  logic        buf_full;
  logic        hold;

  // axi channel registers
  axi_aw_t   aw_q;
  axi_w_t    w_q;
  logic      awvalid_q;
  logic      wvalid_q;
  logic      b_fire;
  logic      req_done;
  logic      load_data;
  logic      load_tail;
  axi_word_u tail_word;

  // sticky status
  logic stop_pend_q;
  logic bresp_err_q;

  // bready tied high, every response accepted
  assign b_fire = axi_i.bvalid;

  // both request channels done, or finishing this cycle
  assign req_done = (!awvalid_q || axi_i.awready) && (!wvalid_q || axi_i.wready);

  // ----------------------------------------------------------
  // ring arithmetic
  // ----------------------------------------------------------
  assign off_inc = off_q + 32'(PHASE_BYTES);
  assign nxt_off = (off_inc == cfg_i.buf_size) ? 32'h0 : off_inc;

  // in CHECK off_q is already the new offset
  assign buf_full = (nxt_off == cfg_i.head);
  assign hold     = buf_full || stop_pend_q;

  // tail record, new offset plus ones fill
  always_comb
  begin
    tail_word.tail.fill   = '1;
    tail_word.tail.offset = nxt_off;
  end

  // no new phase once a stop is pending
  assign phase_take_o = (state_q == ST_WAIT) && phase_valid_i && !stop_pend_q;
  assign load_data    = phase_take_o;
  assign load_tail    = (state_q == ST_DATA_RSP) && b_fire;

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (cfg_i.go)
          state_d = ST_WAIT;
      ST_WAIT:
        if (stop_pend_q)
          state_d = ST_CHECK;
        else if (phase_valid_i)
          state_d = ST_DATA_REQ;
      ST_DATA_REQ:
        if (req_done)
          state_d = ST_DATA_RSP;
      ST_DATA_RSP:
        if (b_fire)
          state_d = ST_TAIL_REQ;
      ST_TAIL_REQ:
        if (req_done)
          state_d = ST_TAIL_RSP;
      ST_TAIL_RSP:
        if (b_fire)
          state_d = ST_CHECK;
      // paused here while full or stopped
      ST_CHECK:
        if (!hold)
          state_d = ST_WAIT;
      default:
        state_d = ST_IDLE;
    endcase
    // write reset wins from any state
    if (cfg_i.reset)
      state_d = ST_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      off_q <= '0;
    else if (cfg_i.go && (state_q == ST_IDLE))
      off_q <= '0;
    else if (load_tail)
      off_q <= nxt_off;
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      stop_pend_q <= 1'b0;
    else if (cfg_i.reset)
      stop_pend_q <= 1'b0;
    else if (cfg_i.stop)
      stop_pend_q <= 1'b1;
  end

  // any slverr/decerr sticks until write reset
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      bresp_err_q <= 1'b0;
    else if (cfg_i.reset)
      bresp_err_q <= 1'b0;
    else if (b_fire && (axi_i.bresp != 2'b00))
      bresp_err_q <= 1'b1;
  end

  // ----------------------------------------------------------
  // axi write channels
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end
    else if (cfg_i.reset)
    begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end
    else if (load_data || load_tail)
    begin
      awvalid_q <= 1'b1;
      wvalid_q  <= 1'b1;
    end
    else
    begin
      // each channel drops on its own ready
      if (axi_i.awready)
        awvalid_q <= 1'b0;
      if (axi_i.wready)
        wvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_data)
    begin
      aw_q.addr   <= cfg_i.base + ADDR_WIDTH'(off_q);
      aw_q.id     <= '0;
      w_q.data    <= phase_i;
      w_q.strb    <= '1;
      w_q.last    <= 1'b1;
    end
    else if (load_tail)
    begin
      // tail slot sits just past the ring
      aw_q.addr   <= cfg_i.base + ADDR_WIDTH'(cfg_i.buf_size);
      aw_q.id     <= '0;
      w_q.data    <= tail_word;
      w_q.strb    <= TAIL_STRB;
      w_q.last    <= 1'b1;
    end
  end

  assign axi_o = '{awvalid: awvalid_q, aw: aw_q, wvalid: wvalid_q, w: w_q};

  assign status_o = '{
    wr_inp:    (state_q != ST_IDLE) && !((state_q == ST_CHECK) && hold),
    stop_pend: stop_pend_q,
    bresp_err: bresp_err_q
  };

  a_aw_stable: assert property (
    @(posedge clk) disable iff (!sync_rst_n)
    (axi_o.awvalid && !axi_i.awready && !cfg_i.reset) |=>
      (axi_o.awvalid && $stable(axi_o.aw))
  );

  a_w_stable: assert property (
    @(posedge clk) disable iff (!sync_rst_n)
    (axi_o.wvalid && !axi_i.wready && !cfg_i.reset) |=>
      (axi_o.wvalid && $stable(axi_o.w))
  );

endmodule

`default_nettype wire

// File: src/fsb_axi_writer_top.sv
// fsb to axi writer top: register block, phase packer and ring writer
`timescale 1ns/100ps
`default_nettype none

module fsb_axi_writer_top (
  input  wire                       clk,
  input  wire                       sync_rst_n,
  // register bus
  input  fsb_axi_pkg::wb_req_t      wb_i,
  output fsb_axi_pkg::wb_rsp_t      wb_o,
  // fsb packet stream
  input  wire                       fsb_valid_i,
  input  fsb_axi_pkg::fsb_pkt_t     fsb_data_i,
  output logic                      fsb_yumi_o,
  // host memory write port
  output fsb_axi_pkg::axi_wr_req_t  axi_o,
  input  fsb_axi_pkg::axi_wr_rsp_t  axi_i
);

  import fsb_axi_pkg::*;

  // ----------------------------------------------------------
  // internal links
  // ----------------------------------------------------------
  ring_cfg_t    ring_cfg;
  ring_status_t ring_status;
  logic         fsb_en;

  // packer to writer
  logic      phase_valid;
  axi_word_u phase;
  logic      phase_take;

  fsb_axi_cfg_regs u_regs (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .wb_i       (wb_i),
    .wb_o       (wb_o),
    .status_i   (ring_status),
    .cfg_o      (ring_cfg),
    .fsb_en_o   (fsb_en)
  );

  fsb_phase_packer u_packer (
    .clk           (clk),
    .sync_rst_n    (sync_rst_n),
    .fsb_en_i      (fsb_en),
    .fsb_valid_i   (fsb_valid_i),
    .fsb_data_i    (fsb_data_i),
    .fsb_yumi_o    (fsb_yumi_o),
    .phase_valid_o (phase_valid),
    .phase_o       (phase),
    .phase_take_i  (phase_take)
  );

  // one axi transaction in flight at a time
  hm_ring_writer u_writer (
    .clk           (clk),
    .sync_rst_n    (sync_rst_n),
    .cfg_i         (ring_cfg),
    .status_o      (ring_status),
    .phase_valid_i (phase_valid),
    .phase_i       (phase),
    .phase_take_o  (phase_take),
    .axi_o         (axi_o),
    .axi_i         (axi_i)
  );

endmodule

`default_nettype wire

// File: verif/tb_fsb_axi_writer.sv
// testbench for the fsb to axi ring writer: fsb driver, axi memory model, wishbone tasks, checker
`timescale 1ns/100ps
`default_nettype none

module tb_fsb_axi_writer;

  import fsb_axi_pkg::*;

  // ----------------------------------------------------------
  // constants
  // ----------------------------------------------------------
  localparam int          HALF    = 20;
  localparam int          QUARTER = 10;
  localparam logic [31:0] SEED    = 32'h0c70a57e;
  localparam logic [63:0] BASE    = 64'h0000_0012_3400_0000;

  // packets per test
  localparam int T2_PKTS = 8;
  localparam int T3_PKTS = 24;
  localparam int T4_PKTS = 16;
  localparam int T4_MORE = 8;
  localparam int T5_PKTS = 64;
  localparam int TOTAL_PKTS      = T2_PKTS + T3_PKTS + T4_PKTS + T4_MORE + T5_PKTS;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 200 + 4000;

  // one write seen by the memory model
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [STRB_WIDTH-1:0] strb;
    axi_word_u             data;
  } wr_rec_t;

  logic        clk;
  logic        sync_rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        fsb_valid;
  fsb_pkt_t    fsb_data;
  logic        fsb_yumi;
  axi_wr_req_t axi_req;
  axi_wr_rsp_t axi_rsp;

  // shared between driver, model and checker
  int                    send_left;
  fsb_pkt_t              sent_q[$];
  wr_rec_t               wr_q[$];
  logic [ADDR_WIDTH-1:0] data_addr_q[$];
  int                    data_seen;
  int                    tail_seen;
  logic [31:0]           exp_off;
  logic                  expect_tail;
  logic [ADDR_WIDTH-1:0] base_r;
  logic [31:0]           size_r;
  logic                  slow_axi;
  int                    check_cnt;
  int                    err_cnt;

  fsb_axi_writer_top DUT (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .wb_i        (wb_req),
    .wb_o        (wb_rsp),
    .fsb_valid_i (fsb_valid),
    .fsb_data_i  (fsb_data),
    .fsb_yumi_o  (fsb_yumi),
    .axi_o       (axi_req),
    .axi_i       (axi_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(HALF) clk = ~clk;
  end

  // ----------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------
  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] st);
    return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(inout logic [31:0] st, input int n,
                           output logic [FSB_WIDTH-1:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      val = {val[FSB_WIDTH-2:0], st[0]};
      st  = lfsr_step(st);
    end
  endtask

  // packet k lands zero-extended in lane k
  function automatic axi_word_u ref_phase(input logic [LANES-1:0][FSB_WIDTH-1:0] grp);
    axi_word_u w;
    int        k;
    for (k = 0; k < LANES; k++)
    begin
      w.lane[k]                = '0;
      w.lane[k][FSB_WIDTH-1:0] = grp[k];
    end
    return w;
  endfunction

  // offset advance with wrap at the buffer size
  function automatic logic [31:0] ref_next_off(input logic [31:0] off, input logic [31:0] size);
    logic [31:0] nxt;
    nxt = off + PHASE_BYTES;
    if (nxt == size)
      nxt = '0;
    return nxt;
  endfunction

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic check_word(input axi_word_u got, input axi_word_u exp, input string what);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ADDR_WIDTH-1:0] got, input logic [ADDR_WIDTH-1:0] exp,
                            input string what);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_strb(input logic [STRB_WIDTH-1:0] got, input logic [STRB_WIDTH-1:0] exp,
                            input string what);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // wishbone master
  // ----------------------------------------------------------
  // stb held through the ack cycle, the write lands there
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!wb_rsp.ack && n < 16);
    if (!wb_rsp.ack)
    begin
      err_cnt++;
      $display("no wishbone ack for offset %h at %0t", adr, $time);
    end
    rdat = wb_rsp.dat;
    @(negedge clk);
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'h0, dat);
  endtask

  // ----------------------------------------------------------
  // test helpers
  // ----------------------------------------------------------
  // write reset, new ring config, then go from offset 0
  task automatic restart_ring(input logic [31:0] size, input logic [31:0] head);
    wb_write(REG_RESET, 32'h1);
    wb_write(REG_BASE_LO, BASE[31:0]);
    wb_write(REG_BASE_HI, BASE[63:32]);
    wb_write(REG_BUF_SIZE, size);
    wb_write(REG_HEAD, head);
    base_r      = BASE;
    size_r      = size;
    exp_off     = '0;
    expect_tail = 1'b0;
    wb_write(REG_CMD, 32'h1);
  endtask

  task automatic wait_pairs(input int n, input int limit);
    int c;
    c = 0;
    while ((data_seen < n || tail_seen < n) && c < limit)
    begin
      @(negedge clk);
      c++;
    end
    if (data_seen < n || tail_seen < n)
    begin
      err_cnt++;
      $display("timed out waiting for %0d data/tail pairs, saw %0d data and %0d tail",
               n, data_seen, tail_seen);
    end
  endtask

  // no new data writes over a window
  task automatic hold_quiet(input int cycles, input string what);
    int n0;
    n0 = data_seen;
    repeat (cycles) @(negedge clk);
    check_reg(data_seen, n0, what);
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
  endtask

  // ----------------------------------------------------------
  // fsb driver, data held until yumi
  // ----------------------------------------------------------
  initial
  begin : fsb_driver
    logic [31:0]          st;
    logic [FSB_WIDTH-1:0] pkt;
    logic [FSB_WIDTH-1:0] gap;
    logic                 have;
    st   = SEED;
    have = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!have && send_left > 0)
      begin
        draw_bits(st, FSB_WIDTH, pkt);
        have = 1'b1;
      end
      // about one idle cycle in four
      draw_bits(st, 2, gap);
      fsb_valid = have && (gap[1:0] != 2'b00);
      fsb_data  = have ? pkt : '0;
      // yumi is settled mid low phase
      #(QUARTER);
      if (fsb_valid && fsb_yumi)
      begin
        sent_q.push_back(pkt);
        send_left--;
        have = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // axi memory model, random ready and response delays
  // ----------------------------------------------------------
  initial
  begin : axi_model
    logic [31:0]          st;
    logic [FSB_WIDTH-1:0] r;
    logic                 got_aw;
    logic                 got_w;
    wr_rec_t              rec;
    st     = SEED;
    got_aw = 1'b0;
    got_w  = 1'b0;
    rec    = '0;
    forever
    begin
      @(negedge clk);
      // bvalid lasts one cycle, bready is always high
      if (axi_rsp.bvalid)
        axi_rsp.bvalid = 1'b0;
      else if (got_aw && got_w)
      begin
        draw_bits(st, 1, r);
        if (r[0])
        begin
          wr_q.push_back(rec);
          axi_rsp.bvalid = 1'b1;
          got_aw         = 1'b0;
          got_w          = 1'b0;
        end
      end
      draw_bits(st, 2, r);
      axi_rsp.awready = slow_axi ? (r[1:0] == 2'b00) : r[0];
      draw_bits(st, 2, r);
      axi_rsp.wready = slow_axi ? (r[1:0] == 2'b00) : r[0];
      #(QUARTER);
      if (axi_req.awvalid && axi_rsp.awready)
      begin
        rec.addr = axi_req.aw.addr;
        got_aw   = 1'b1;
      end
      if (axi_req.wvalid && axi_rsp.wready)
      begin
        rec.strb = axi_req.w.strb;
        rec.data = axi_req.w.data;
        got_w    = 1'b1;
        if (!axi_req.w.last)
        begin
          err_cnt++;
          $display("write beat without wlast at %0t", $time);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // ring checker, data and tail writes in strict order
  // ----------------------------------------------------------
  initial
  begin : ring_checker
    wr_rec_t                         rec;
    logic [LANES-1:0][FSB_WIDTH-1:0] grp;
    axi_word_u                       exp_w;
    int                              k;
    forever
    begin
      @(posedge clk);
      while (wr_q.size() > 0)
      begin
        rec = wr_q.pop_front();
        if (!expect_tail)
        begin
          check_addr(rec.addr, base_r + ADDR_WIDTH'(exp_off), "data address");
          check_strb(rec.strb, '1, "data strobe");
          if (sent_q.size() < LANES)
          begin
            err_cnt++;
            $display("data write at %0t with only %0d packets consumed", $time, sent_q.size());
          end
          else
          begin
            for (k = 0; k < LANES; k++)
              grp[k] = sent_q.pop_front();
            check_word(rec.data, ref_phase(grp), "data phase");
          end
          data_addr_q.push_back(rec.addr);
          data_seen++;
          exp_off     = ref_next_off(exp_off, size_r);
          expect_tail = 1'b1;
        end
        else
        begin
          // tail slot right after the ring
          check_addr(rec.addr, base_r + ADDR_WIDTH'(size_r), "tail address");
          check_strb(rec.strb, 64'hff, "tail strobe");
          exp_w.tail.fill   = '1;
          exp_w.tail.offset = exp_off;
          check_word(rec.data, exp_w, "tail record");
          tail_seen++;
          expect_tail = 1'b0;
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial
  begin : main_seq
    logic [31:0] v;
    int          e0;
    int          base_cnt;
    int          idx;
    int          tries;
    sync_rst_n  = 1'b0;
    wb_req      = '0;
    fsb_valid   = 1'b0;
    fsb_data    = '0;
    axi_rsp     = '0;
    send_left   = 0;
    data_seen   = 0;
    tail_seen   = 0;
    exp_off     = '0;
    expect_tail = 1'b0;
    base_r      = '0;
    size_r      = '0;
    slow_axi    = 1'b0;
    check_cnt   = 0;
    err_cnt     = 0;
    repeat (5) @(negedge clk);
    sync_rst_n = 1'b1;

    // register readback
    e0 = err_cnt;
    wb_write(REG_CTRL, 32'h1);
    wb_write(REG_BASE_LO, 32'h1234_5678);
    wb_write(REG_BASE_HI, 32'h9abc_def0);
    wb_write(REG_HEAD, 32'h0000_0a40);
    wb_write(REG_BUF_SIZE, 32'h0001_0000);
    wb_read(REG_CTRL, v);
    check_reg(v, 32'h1, "ctrl readback");
    wb_read(REG_BASE_LO, v);
    check_reg(v, 32'h1234_5678, "base lo readback");
    wb_read(REG_BASE_HI, v);
    check_reg(v, 32'h9abc_def0, "base hi readback");
    wb_read(REG_HEAD, v);
    check_reg(v, 32'h0000_0a40, "head readback");
    wb_read(REG_BUF_SIZE, v);
    check_reg(v, 32'h0001_0000, "buffer size readback");
    wb_read(8'h3c, v);
    check_reg(v, 32'hffff_ffff, "unmapped offset 0x3c");
    wb_read(8'h10, v);
    check_reg(v, 32'hffff_ffff, "unmapped offset 0x10");
    wb_read(REG_CMD, v);
    check_reg(v, 32'h0, "idle status");
    end_test(1, "register readback", e0);

    // data phases each followed by a tail record
    e0 = err_cnt;
    restart_ring(32'd4096, 32'd0);
    base_cnt = data_seen;
    send_left += T2_PKTS;
    wait_pairs(base_cnt + T2_PKTS / LANES, 5000);
    check_reg(tail_seen, data_seen, "tail writes per data write");
    end_test(2, "data and tail writes", e0);

    // 4-phase ring, full at three phases with head 0
    e0 = err_cnt;
    restart_ring(32'd256, 32'd0);
    base_cnt = data_seen;
    send_left += T3_PKTS;
    wait_pairs(base_cnt + 3, 5000);
    hold_quiet(60, "data writes while buffer full");
    wb_read(REG_CMD, v);
    check_reg(v, 32'h0, "status while buffer full");
    // head moves, two more phases fit
    wb_write(REG_HEAD, 32'd128);
    wait_pairs(base_cnt + 5, 5000);
    // sixth phase is waiting in the packer here
    hold_quiet(60, "data writes after second full");
    // head moves again, one more phase fits
    wb_write(REG_HEAD, 32'd192);
    wait_pairs(base_cnt + 6, 5000);
    check_addr(data_addr_q[base_cnt + 3], BASE + 64'd192, "last address before wrap");
    check_addr(data_addr_q[base_cnt + 4], BASE, "wrapped data address");
    check_addr(data_addr_q[base_cnt + 5], BASE + 64'd64, "data address after wrap");
    check_reg(send_left, 32'd0, "packets still unsent");
    end_test(3, "ring wrap and full pause", e0);

    // soft stop, then write reset and a fresh go
    e0 = err_cnt;
    restart_ring(32'd4096, 32'd0);
    base_cnt = data_seen;
    send_left += T4_PKTS;
    wait_pairs(base_cnt + 1, 5000);
    wb_write(REG_CMD, 32'h0);
    v     = '0;
    tries = 0;
    while (!(v[1] && !v[0]) && tries < 50)
    begin
      wb_read(REG_CMD, v);
      tries++;
    end
    check_reg(v, 32'h2, "status after stop");
    check_reg(tail_seen, data_seen, "complete pairs at stop");
    hold_quiet(60, "data writes while stopped");
    wb_write(REG_RESET, 32'h1);
    wb_read(REG_CMD, v);
    check_reg(v, 32'h0, "status after write reset");
    idx = data_seen;
    restart_ring(32'd4096, 32'd0);
    send_left += T4_MORE;
    wait_pairs(base_cnt + (T4_PKTS + T4_MORE) / LANES, 5000);
    check_addr(data_addr_q[idx], BASE, "first data address after restart");
    end_test(4, "stop and restart", e0);

    // long run with slow axi readies and fsb gaps
    e0 = err_cnt;
    slow_axi = 1'b1;
    restart_ring(32'd2048, 32'd0);
    base_cnt = data_seen;
    send_left += T5_PKTS;
    wait_pairs(base_cnt + T5_PKTS / LANES, 20000);
    check_reg(send_left, 32'd0, "packets still unsent");
    check_reg(sent_q.size(), 32'd0, "consumed packets never written");
    wb_read(REG_CMD, v);
    check_reg(v, 32'h1, "status while running");
    slow_axi = 1'b0;
    end_test(5, "random back-pressure", e0);

    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/fsb_axi_pkg.sv
src/fsb_axi_cfg_regs.sv
src/fsb_phase_packer.sv
src/hm_ring_writer.sv
src/fsb_axi_writer_top.sv
verif/tb_fsb_axi_writer.sv

// File: Bender.yml
package:
  name: fsb_axi_writer

sources:
  - src/fsb_axi_pkg.sv
  - src/fsb_axi_cfg_regs.sv
  - src/fsb_phase_packer.sv
  - src/hm_ring_writer.sv
  - src/fsb_axi_writer_top.sv
  - target: test
    files:
      - verif/tb_fsb_axi_writer.sv
